// File: dv/adc_dump_testdata.txt
// code a_base a_end b_base b_end control ready_mask stall slverr late_control
// control and late_control: bit0 enables channel A, bit1 channel B
01 10000000 10100000 20000000 20100000 1 1 0 0 1
02 10000000 10000900 20000000 20100000 3 3 0 0 3
03 10000000 10100000 20000000 20100000 1 4 0 0 3
04 10000000 10100000 20000000 20100000 3 f 1 0 3
05 10004000 10005000 20008000 20008c00 3 6 1 0 3
06 10000000 10100000 20000000 20100000 2 8 0 1 2

// File: all.f
+incdir+design
design/axi_pkg.sv
design/dump_pkg.sv
design/dump_job_if.sv
design/ddr_addr_track.sv
design/dump_sched.sv
design/axi_burst_writer.sv
design/adc_dump_top.sv
dv/adc_dump_chk.sv
dv/tb_adc_dump.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ADC dump simulation with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_dump \
  -f all.f -o sim_adc_dump > build.log 2>&1 &&
  ./obj_dir/sim_adc_dump > sim.log 2>&1 ||
  { cat build.log sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1
grep -q "Everything OK" sim.log || exit 1
exit 0

// File: dv/tb_adc_dump.sv
// ----------------------------------------------------------------------
// ADC dump testbench
// buffer model, AXI slave with random stalls, address and data
// scoreboard and watchdog, driven from the testdata file
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

module tb_adc_dump;

  localparam int PERIOD   = 100;
  localparam int N_TESTS  = 6;
  localparam int N_FIELDS = 10;

  logic        clk;
  logic        reset_i;
  logic [3:0]  rdy;
  logic [1:0]  adcbuf_select_o;
  logic [8:0]  adcbuf_raddr_o;
  logic [63:0] rdata;
  logic [3:0]  adcbuf_release_o;
  logic [31:0] a_base;
  logic [31:0] a_end;
  logic [31:0] b_base;
  logic [31:0] b_end;
  logic [31:0] a_curr;
  logic [31:0] b_curr;
  logic [3:0]  ctrl;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [3:0]  awlen;
  logic [1:0]  awburst;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic        err;

  logic [31:0] td [0:N_TESTS*N_FIELDS-1];
  integer      seed = 32'hcb2d_634a;
  int          errors;
  int          aw_n;
  int          wl_n;
  int          b_n;
  int          wcnt;
  int          awcnt;
  int          rel_cnt [4];
  logic [31:0] ptr [2];
  logic [1:0]  rd_half;
  logic [1:0]  last_served;
  logic [7:0]  rd_word;
  logic [3:0]  rel_pend;
  logic        stall;
  logic        slverr;
  string       tname;

  adc_dump_top UUT (
    .axi_clk_i        (clk),
    .reset_i          (reset_i),
    .adcbuf_ready_i   (rdy),
    .adcbuf_select_o  (adcbuf_select_o),
    .adcbuf_raddr_o   (adcbuf_raddr_o),
    .adcbuf_rdata_i   (rdata),
    .adcbuf_release_o (adcbuf_release_o),
    .ddrd_a_base_i    (a_base),
    .ddrd_a_end_i     (a_end),
    .ddrd_b_base_i    (b_base),
    .ddrd_b_end_i     (b_end),
    .ddrd_control_i   (ctrl),
    .ddrd_a_curr_o    (a_curr),
    .ddrd_b_curr_o    (b_curr),
    .axi_awaddr_o     (awaddr),
    .axi_awvalid_o    (awvalid),
    .axi_awready_i    (awready),
    .axi_awlen_o      (awlen),
    .axi_awburst_o    (awburst),
    .axi_wdata_o      (wdata),
    .axi_wstrb_o      (wstrb),
    .axi_wlast_o      (wlast),
    .axi_wvalid_o     (wvalid),
    .axi_wready_i     (wready),
    .axi_bresp_i      (axi_pkg::resp_e'(bresp)),
    .axi_bvalid_i     (bvalid),
    .axi_bready_o     (bready),
    .dump_err_o       (err)
  );

  always #(PERIOD/2) clk = ~clk;

  // buffer word i of half h
  function automatic logic [63:0] word_of(input logic [1:0] h, input logic [7:0] i);
    return {8'ha5, 6'd0, h, 24'd0, i, ~{6'd0, h, i}};
  endfunction

  // first ready and enabled half after the last one served
  function automatic logic [1:0] next_half(input logic [1:0] last, input logic [3:0] m,
                                           input logic [1:0] en);
    logic [1:0] c;
    next_half = last;
    for (int i = 4; i >= 1; i--) begin
      c = last + 2'(i);
      if (m[c] && en[c[1]]) next_half = c;
    end
  endfunction

  task automatic fail_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("Fail %s %s: expected %h, actual %h", tname, what, exp, act);
  endtask

  // ------------------------------------------------------------------
  // monitors at the falling edge
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    int         idx;
    logic [1:0] exp_half;
    rd_half = {adcbuf_select_o[1], adcbuf_raddr_o[8]};
    rd_word = adcbuf_raddr_o[7:0];
    if (reset_i) begin
      aw_n = 0;
      wl_n = 0;
      b_n  = 0;
    end else begin
      exp_half = next_half(last_served, rdy, ctrl[1:0]);
      if (awvalid && awready) begin
        if (adcbuf_select_o !== exp_half) begin
          fail_val("select", exp_half, adcbuf_select_o);
        end
        if (awaddr !== ptr[exp_half[1]]) begin
          fail_val("awaddr", ptr[exp_half[1]], awaddr);
        end
        if (awlen !== 4'd15 || awburst !== 2'b01) begin
          fail_val("awlen/burst", {4'd15, 2'b01}, {awlen, awburst});
        end
        ptr[exp_half[1]] = ptr[exp_half[1]] + 32'd128;
        if (ptr[0] >= a_end) ptr[0] = a_base;   // ring wrap
        if (ptr[1] >= b_end) ptr[1] = b_base;
        awcnt++;
        aw_n++;
      end
      if (wvalid && wready) begin
        if (wdata !== word_of(exp_half, 8'(wcnt))) begin
          fail_val("wdata", word_of(exp_half, 8'(wcnt)), wdata);
        end
        if (wlast !== (wcnt % 16 == 15)) fail_val("wlast", (wcnt % 16 == 15), wlast);
        if (wstrb !== 8'hff) fail_val("wstrb", 8'hff, wstrb);
        if (wlast) wl_n++;
        wcnt++;
      end
      if (bvalid && bready !== 1'b1) fail_val("bready", 1'b1, bready);
      if (adcbuf_release_o != 4'b0) begin
        idx = 0;
        for (int h = 0; h < 4; h++) begin
          if (adcbuf_release_o[h]) idx = h;
        end
        if (idx != exp_half) fail_val("release half", exp_half, idx);
        if (wcnt != 256 || awcnt != 16) begin
          fail_val("beats/bursts", {32'd256, 32'd16}, {wcnt, awcnt});
        end
        if (a_curr !== ptr[0]) fail_val("a_curr", ptr[0], a_curr);
        if (b_curr !== ptr[1]) fail_val("b_curr", ptr[1], b_curr);
        rel_cnt[idx]++;
        last_served = 2'(idx);
        rel_pend    = adcbuf_release_o;
        wcnt  = 0;
        awcnt = 0;
      end
    end
  end

  // buffer read data and slave responses
  always @(posedge clk) begin
    #5;
    rdata    = word_of(rd_half, rd_word);
    awready  = stall ? 1'($random(seed)) : 1'b1;
    wready   = stall ? 1'($random(seed)) : 1'b1;
    rdy      = rdy & ~rel_pend;
    rel_pend = 4'b0;
    bresp    = slverr ? 2'b10 : 2'b00;
    if (reset_i) begin
      bvalid = 1'b0;
    end else if (bvalid) begin
      bvalid = 1'b0;
      b_n++;
    end else if (aw_n > b_n && wl_n > b_n) begin
      bvalid = 1'b1;
    end
  end

  task automatic wait_idle();
    while ((rdy & {{2{ctrl[1]}}, {2{ctrl[0]}}}) != 4'b0) @(posedge clk);
    repeat (4) @(posedge clk);
    #5;
  endtask

  task automatic run_test(input int t);
    logic [3:0] mask;
    int         b;
    b     = t * N_FIELDS;
    tname = $sformatf("test%0h", td[b]);
    @(posedge clk) #5;
    reset_i = 1'b1;
    ctrl    = '0;
    rdy     = '0;
    stall   = 1'b0;
    slverr  = 1'b0;
    repeat (2) @(posedge clk);
    #5 reset_i = 1'b0;
    last_served = 2'd3;
    rel_cnt = '{0, 0, 0, 0};
    @(negedge clk);
    if (awvalid !== 1'b0 || wvalid !== 1'b0 || adcbuf_release_o !== 4'b0 || err !== 1'b0) begin
      fail_val("idle outputs", 7'd0, {awvalid, wvalid, adcbuf_release_o, err});
    end
    if ({a_curr, b_curr} !== 64'd0) fail_val("curr after reset", 64'd0, {a_curr, b_curr});
    @(posedge clk) #5;
    a_base = td[b+1];
    a_end  = td[b+2];
    b_base = td[b+3];
    b_end  = td[b+4];
    ctrl = 4'b1100;                        // reload both pointers
    @(posedge clk) #5;
    ctrl = 4'(td[b+5]) & 4'b0011;
    ptr  = '{a_base, b_base};
    @(negedge clk);
    if ({a_curr, b_curr} !== {a_base, b_base}) begin
      fail_val("reload", {a_base, b_base}, {a_curr, b_curr});
    end
    @(posedge clk) #5;
    mask   = 4'(td[b+6]);
    rdy    = mask;
    stall  = td[b+7][0];
    slverr = td[b+8][0];
    wait_idle();
    ctrl = 4'(td[b+9]) & 4'b0011;          // late enable
    wait_idle();
    for (int h = 0; h < 4; h++) begin
      if (rel_cnt[h] != int'(mask[h] && ctrl[h/2])) begin
        fail_val("releases", mask[h] && ctrl[h/2], rel_cnt[h]);
      end
    end
    if (err !== slverr) fail_val("dump_err", slverr, err);
    if (slverr) begin
      // error flag clears only with reset
      @(posedge clk) #5;
      reset_i = 1'b1;
      repeat (2) @(posedge clk);
      #5 reset_i = 1'b0;
      @(negedge clk);
      if (err !== 1'b0) fail_val("dump_err after reset", 1'b0, err);
    end
  endtask

  initial begin
    clk         = 1'b0;
    reset_i     = 1'b0;
    rdy         = '0;
    ctrl        = '0;
    stall       = 1'b0;
    slverr      = 1'b0;
    rel_pend    = '0;
    a_base      = '0;
    a_end       = '0;
    b_base      = '0;
    b_end       = '0;
    rdata       = '0;
    awready     = 1'b0;
    wready      = 1'b0;
    bvalid      = 1'b0;
    bresp       = '0;
    rd_half     = '0;
    rd_word     = '0;
    errors      = 0;
    wcnt        = 0;
    awcnt       = 0;
    last_served = 2'd3;
    $readmemh("dv/adc_dump_testdata.txt", td);
    for (int t = 0; t < N_TESTS; t++) run_test(t);
    $display("errors: %0d, assertion failures: %0d", errors, UUT.u_chk.fail_cnt);
    if (errors + UUT.u_chk.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog allows 64 cycles per burst
  initial begin
    #(64'(N_TESTS) * 4 * 16 * 64 * PERIOD);
    $display("timeout: the dump did not finish in time");
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/adc_dump_chk.sv
// ----------------------------------------------------------------------
// ADC dump protocol checker
// AXI write channel and burst job handshake assertions, bound into
// the dump top level
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module adc_dump_chk (
  input wire logic        axi_clk_i,
  input wire logic        reset_i,
  input wire logic        awvalid_i,
  input wire logic        awready_i,
  input wire logic [31:0] awaddr_i,
  input wire logic        wvalid_i,
  input wire logic        wready_i,
  input wire logic        wlast_i,
  input wire logic        job_stb_i,
  input wire logic        job_ack_i
);

  logic [3:0] beat_q;         // accepted beats within the burst
  int         fail_cnt = 0;   // failed assertions so far

  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      beat_q <= '0;
    end else if (wvalid_i && wready_i) begin
      beat_q <= beat_q + 4'd1;
    end
  end

  a_aw_hold: assert property (@(posedge axi_clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else begin
      $error("awvalid dropped before accept");
      fail_cnt++;
    end

  a_awaddr_hold: assert property (@(posedge axi_clk_i) disable iff (reset_i)
    awvalid_i && !awready_i |=> $stable(awaddr_i))
    else begin
      $error("awaddr changed under stall");
      fail_cnt++;
    end

  a_w_hold: assert property (@(posedge axi_clk_i) disable iff (reset_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else begin
      $error("wvalid dropped before accept");
      fail_cnt++;
    end

  // wlast on every sixteenth accepted beat only
  a_wlast: assert property (@(posedge axi_clk_i) disable iff (reset_i)
    wvalid_i && wready_i |-> (wlast_i == (beat_q == 4'd15)))
    else begin
      $error("wlast misplaced");
      fail_cnt++;
    end

  a_ack_stb: assert property (@(posedge axi_clk_i) disable iff (reset_i)
    job_ack_i |-> job_stb_i)
    else begin
      $error("job ack without stb");
      fail_cnt++;
    end

endmodule

bind adc_dump_top adc_dump_chk u_chk (
  .axi_clk_i (axi_clk_i),
  .reset_i   (reset_i),
  .awvalid_i (axi_awvalid_o),
  .awready_i (axi_awready_i),
  .awaddr_i  (axi_awaddr_o),
  .wvalid_i  (axi_wvalid_o),
  .wready_i  (axi_wready_i),
  .wlast_i   (axi_wlast_o),
  .job_stb_i (u_job.stb),
  .job_ack_i (u_job.ack)
);

`default_nettype wire

// File: design/adc_dump_top.sv
// ----------------------------------------------------------------------
// ADC dump to DDR
// moves full halves of the two-channel ADC buffer into DDR ring
// regions through AXI3 write bursts on the HP port
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

module adc_dump_top (
  input  wire logic                       axi_clk_i,
  input  wire logic                       reset_i,
  // ADC sample buffer
  input  wire logic [3:0]                 adcbuf_ready_i,
  output      dump_pkg::half_t            adcbuf_select_o,
  output      logic [`DUMP_BUF_AW-1:0]    adcbuf_raddr_o,
  input  wire logic [`DUMP_AXI_DW-1:0]    adcbuf_rdata_i,
  output      logic [3:0]                 adcbuf_release_o,
  // dump settings
  input  wire logic [`DUMP_AXI_AW-1:0]    ddrd_a_base_i,
  input  wire logic [`DUMP_AXI_AW-1:0]    ddrd_a_end_i,
  input  wire logic [`DUMP_AXI_AW-1:0]    ddrd_b_base_i,
  input  wire logic [`DUMP_AXI_AW-1:0]    ddrd_b_end_i,
  input  wire logic [3:0]                 ddrd_control_i,   // [1:0] enable, [3:2] reload
  output      logic [`DUMP_AXI_AW-1:0]    ddrd_a_curr_o,
  output      logic [`DUMP_AXI_AW-1:0]    ddrd_b_curr_o,
  // AXI write address channel
  output      logic [`DUMP_AXI_AW-1:0]    axi_awaddr_o,
  output      logic                       axi_awvalid_o,
  input  wire logic                       axi_awready_i,
  output      logic [3:0]                 axi_awlen_o,
  output      axi_pkg::burst_e            axi_awburst_o,
  // AXI write data channel
  output      logic [`DUMP_AXI_DW-1:0]    axi_wdata_o,
  output      logic [`DUMP_AXI_DW/8-1:0]  axi_wstrb_o,
  output      logic                       axi_wlast_o,
  output      logic                       axi_wvalid_o,
  input  wire logic                       axi_wready_i,
  // AXI write response channel
  input  wire axi_pkg::resp_e             axi_bresp_i,
  input  wire logic                       axi_bvalid_i,
  output      logic                       axi_bready_o,
  output      logic                       dump_err_o
);

  logic            advance;
  dump_pkg::chan_t advance_ch;

  dump_job_if u_job ();

  ddr_addr_track u_track (
    .axi_clk_i    (axi_clk_i),
    .reset_i      (reset_i),
    .a_base_i     (ddrd_a_base_i),
    .a_end_i      (ddrd_a_end_i),
    .b_base_i     (ddrd_b_base_i),
    .b_end_i      (ddrd_b_end_i),
    .reload_i     (ddrd_control_i[3:2]),
    .advance_i    (advance),
    .advance_ch_i (advance_ch),
    .a_curr_o     (ddrd_a_curr_o),
    .b_curr_o     (ddrd_b_curr_o)
  );

  dump_sched u_sched (
    .axi_clk_i    (axi_clk_i),
    .reset_i      (reset_i),
    .ready_i      (adcbuf_ready_i),
    .enable_i     (ddrd_control_i[1:0]),
    .a_curr_i     (ddrd_a_curr_o),
    .b_curr_i     (ddrd_b_curr_o),
    .select_o     (adcbuf_select_o),
    .release_o    (adcbuf_release_o),
    .advance_o    (advance),
    .advance_ch_o (advance_ch),
    .job          (u_job.sched)
  );

  axi_burst_writer u_writer (
    .axi_clk_i (axi_clk_i),
    .reset_i   (reset_i),
    .raddr_o   (adcbuf_raddr_o),
    .rdata_i   (adcbuf_rdata_i),
    .awaddr_o  (axi_awaddr_o),
    .awvalid_o (axi_awvalid_o),
    .awready_i (axi_awready_i),
    .awlen_o   (axi_awlen_o),
    .awburst_o (axi_awburst_o),
    .wdata_o   (axi_wdata_o),
    .wstrb_o   (axi_wstrb_o),
    .wlast_o   (axi_wlast_o),
    .wvalid_o  (axi_wvalid_o),
    .wready_i  (axi_wready_i),
    .bresp_i   (axi_bresp_i),
    .bvalid_i  (axi_bvalid_i),
    .bready_o  (axi_bready_o),
    .err_o     (dump_err_o),
    .job       (u_job.writer)
  );

endmodule

`default_nettype wire

// File: design/axi_burst_writer.sv
// ----------------------------------------------------------------------
// AXI3 burst writer
// turns one burst job into an INCR write address, sixteen data beats
// fetched from the sample buffer, and a write response wait
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

module axi_burst_writer (
  input  wire logic                       axi_clk_i,
  input  wire logic                       reset_i,
  // sample buffer read port
  output      logic [`DUMP_BUF_AW-1:0]    raddr_o,
  input  wire logic [`DUMP_AXI_DW-1:0]    rdata_i,
  // write address channel
  output      logic [`DUMP_AXI_AW-1:0]    awaddr_o,
  output      logic                       awvalid_o,
  input  wire logic                       awready_i,
  output      logic [3:0]                 awlen_o,
  output      axi_pkg::burst_e            awburst_o,
  // write data channel
  output      logic [`DUMP_AXI_DW-1:0]    wdata_o,
  output      logic [`DUMP_AXI_DW/8-1:0]  wstrb_o,
  output      logic                       wlast_o,
  output      logic                       wvalid_o,
  input  wire logic                       wready_i,
  // write response channel
  input  wire axi_pkg::resp_e             bresp_i,
  input  wire logic                       bvalid_i,
  output      logic                       bready_o,
  output      logic                       err_o,
  dump_job_if.writer                      job
);

  logic                     busy_q;
  logic                     ack_q;
  logic                     err_q;
  logic                     awvalid_q;
  logic                     wvalid_q;
  logic [3:0]               beat_q;
  logic [`DUMP_BUF_AW-1:0]  raddr_q;    // word now on rdata_i
  logic [`DUMP_BUF_AW-1:0]  raddr_n;
  logic [`DUMP_AXI_AW-1:0]  awaddr_q;
  logic                     start;
  logic                     beat_ok;
  logic                     last_beat;

  assign start     = job.cyc && job.stb && !busy_q && !ack_q;
  assign beat_ok   = wvalid_q && wready_i;
  assign last_beat = (beat_q == 4'(`DUMP_BURST_LEN - 1));

  // next read address goes out one cycle ahead of its data
  always_comb begin
    raddr_n = raddr_q;
    if (start) begin
      raddr_n = job.word_base;
    end else if (beat_ok && !last_beat) begin
      raddr_n = {raddr_q[`DUMP_BUF_AW-1], raddr_q[`DUMP_BUF_AW-2:0] + 1'b1};
    end
  end

  // ------------------------------------------------------------------
  // address, data and response phases
  // ------------------------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      busy_q    <= 1'b0;
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      beat_q    <= '0;
      raddr_q   <= '0;
    end else begin
      raddr_q <= raddr_n;
      ack_q   <= 1'b0;
      if (start) begin
        busy_q    <= 1'b1;
        awvalid_q <= 1'b1;
        wvalid_q  <= 1'b1;              // first word arrives with it
        beat_q    <= '0;
      end
      if (awvalid_q && awready_i) begin
        awvalid_q <= 1'b0;
      end
      if (beat_ok) begin
        beat_q <= beat_q + 4'd1;
        if (last_beat) begin
          wvalid_q <= 1'b0;
        end
      end
      if (busy_q && bvalid_i) begin     // bready is always high
        busy_q <= 1'b0;
        ack_q  <= 1'b1;
        if (bresp_i != axi_pkg::RESP_OKAY) begin
          err_q <= 1'b1;                // sticky until reset
        end
      end
    end
  end

  always_ff @(posedge axi_clk_i) begin
    if (start) begin
      awaddr_q <= job.adr;
    end
  end

  assign raddr_o   = raddr_n;
  assign awaddr_o  = awaddr_q;
  assign awvalid_o = awvalid_q;
  assign awlen_o   = 4'(`DUMP_BURST_LEN - 1);
  assign awburst_o = axi_pkg::BURST_INCR;
  assign wdata_o   = rdata_i;           // held while the address holds
  assign wstrb_o   = '1;
  assign wlast_o   = last_beat;
  assign wvalid_o  = wvalid_q;
  assign bready_o  = 1'b1;
  assign err_o     = err_q;
  assign job.ack   = ack_q;

endmodule

`default_nettype wire

// File: design/dump_sched.sv
// ----------------------------------------------------------------------
// Dump scheduler
// picks a ready and enabled buffer half in rotating order, issues its
// sixteen burst jobs one at a time and then releases the half
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

module dump_sched (
  input  wire logic                     axi_clk_i,
  input  wire logic                     reset_i,
  input  wire logic [3:0]               ready_i,     // one bit per half
  input  wire logic [`DUMP_CH-1:0]      enable_i,    // one bit per channel
  input  wire logic [`DUMP_AXI_AW-1:0]  a_curr_i,
  input  wire logic [`DUMP_AXI_AW-1:0]  b_curr_i,
  output      dump_pkg::half_t          select_o,
  output      logic [3:0]               release_o,
  output      logic                     advance_o,
  output      dump_pkg::chan_t          advance_ch_o,
  dump_job_if.sched                     job
);

  dump_pkg::sched_state_e state_q;
  dump_pkg::half_t        sel_q;     // half being dumped
  dump_pkg::half_t        last_q;    // last half served
  dump_pkg::half_t        pick;
  logic                   pick_ok;
  logic [3:0]             burst_q;
  logic                   last_burst;

  // rotating scan, starts right after the last served half
  always_comb begin
    pick    = last_q;
    pick_ok = 1'b0;
    for (int i = 1; i <= 4; i++) begin
      dump_pkg::half_t cand;
      cand = last_q + 2'(i);
      if (!pick_ok && ready_i[cand] && enable_i[cand[1]]) begin
        pick    = cand;
        pick_ok = 1'b1;
      end
    end
  end

  assign last_burst = (burst_q == 4'(`DUMP_BURSTS_PER_HALF - 1));

  // ------------------------------------------------------------------
  // state machine
  // ------------------------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      state_q <= dump_pkg::IDLE;
      sel_q   <= '0;
      last_q  <= 2'd3;                  // first scan starts at half 0
      burst_q <= '0;
    end else begin
      case (state_q)
        dump_pkg::IDLE: if (pick_ok) begin
          sel_q   <= pick;
          burst_q <= '0;
          state_q <= dump_pkg::ISSUE;
        end
        dump_pkg::ISSUE: if (job.ack) begin
          burst_q <= burst_q + 4'd1;
          state_q <= last_burst ? dump_pkg::RELEASE : dump_pkg::WAIT;
        end
        dump_pkg::WAIT:    state_q <= dump_pkg::ISSUE;   // new pointer now valid
        dump_pkg::RELEASE: begin
          last_q  <= sel_q;
          state_q <= dump_pkg::IDLE;
        end
        default: state_q <= dump_pkg::IDLE;
      endcase
    end
  end

  // job fields, stable for the whole ISSUE phase
  assign job.cyc       = (state_q == dump_pkg::ISSUE) || (state_q == dump_pkg::WAIT);
  assign job.stb       = (state_q == dump_pkg::ISSUE);
  assign job.adr       = sel_q[1] ? b_curr_i : a_curr_i;
  assign job.word_base = {sel_q[0], 8'(burst_q * `DUMP_BURST_LEN)};

  assign advance_o    = (state_q == dump_pkg::ISSUE) && job.ack;
  assign advance_ch_o = sel_q[1];
  assign select_o     = sel_q;
  assign release_o    = (state_q == dump_pkg::RELEASE) ? (4'b0001 << sel_q) : 4'b0000;

endmodule

`default_nettype wire

// File: design/ddr_addr_track.sv
// ----------------------------------------------------------------------
// DDR write pointer tracker
// keeps one ring write pointer per channel, reloads it from the base,
// advances it by one burst and wraps it at the channel end
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

module ddr_addr_track (
  input  wire logic                     axi_clk_i,
  input  wire logic                     reset_i,
  input  wire logic [`DUMP_AXI_AW-1:0]  a_base_i,
  input  wire logic [`DUMP_AXI_AW-1:0]  a_end_i,    // last address + 1
  input  wire logic [`DUMP_AXI_AW-1:0]  b_base_i,
  input  wire logic [`DUMP_AXI_AW-1:0]  b_end_i,
  input  wire logic [`DUMP_CH-1:0]      reload_i,   // per channel
  input  wire logic                     advance_i,
  input  wire dump_pkg::chan_t          advance_ch_i,
  output      logic [`DUMP_AXI_AW-1:0]  a_curr_o,
  output      logic [`DUMP_AXI_AW-1:0]  b_curr_o
);

  logic [`DUMP_AXI_AW-1:0] base_v  [`DUMP_CH];
  logic [`DUMP_AXI_AW-1:0] end_v   [`DUMP_CH];
  logic [`DUMP_AXI_AW-1:0] curr_q  [`DUMP_CH];
  logic [`DUMP_AXI_AW-1:0] adv_sum [`DUMP_CH];

  assign base_v[0] = a_base_i;
  assign base_v[1] = b_base_i;
  assign end_v[0]  = a_end_i;
  assign end_v[1]  = b_end_i;

  always_comb begin
    for (int ch = 0; ch < `DUMP_CH; ch++) begin
      adv_sum[ch] = curr_q[ch] + `DUMP_AXI_AW'(`DUMP_BURST_BYTES);
    end
  end

  // ------------------------------------------------------------------
  // pointer update, reload wins over advance
  // ------------------------------------------------------------------
  always_ff @(posedge axi_clk_i) begin
    if (reset_i) begin
      for (int ch = 0; ch < `DUMP_CH; ch++) begin
        curr_q[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `DUMP_CH; ch++) begin
        if (reload_i[ch]) begin
          curr_q[ch] <= base_v[ch];
        end else if (advance_i && (advance_ch_i == dump_pkg::chan_t'(ch))) begin
          curr_q[ch] <= (adv_sum[ch] >= end_v[ch]) ? base_v[ch]   // ring wrap
                                                   : adv_sum[ch];
        end
      end
    end
  end

  assign a_curr_o = curr_q[0];
  assign b_curr_o = curr_q[1];

endmodule

`default_nettype wire

// File: design/dump_job_if.sv
// ----------------------------------------------------------------------
// Dump burst job port
// one burst job from the scheduler to the AXI writer, Wishbone
// classic handshake: cyc/stb held with stable fields until ack
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "dump_params.svh"

interface dump_job_if;

  logic                     cyc;
  logic                     stb;
  logic [`DUMP_AXI_AW-1:0]  adr;        // DDR byte address of the burst
  logic [`DUMP_BUF_AW-1:0]  word_base;  // first buffer word of the burst
  logic                     ack;        // one pulse per finished burst

  modport sched (
    output cyc, stb, adr, word_base,
    input  ack
  );

  modport writer (
    input  cyc, stb, adr, word_base,
    output ack
  );

endinterface

`default_nettype wire

// File: design/dump_pkg.sv
// ----------------------------------------------------------------------
// Dump engine types
// scheduler states plus buffer half and channel indices
// ----------------------------------------------------------------------
`default_nettype none

package dump_pkg;

  typedef enum logic [1:0] {
    IDLE,      // scanning for a ready half
    ISSUE,     // job offered to the writer
    WAIT,      // gap after ack, pointer settles
    RELEASE    // hand the half back to the buffer
  } sched_state_e;

  // halves 0,1 are channel A, halves 2,3 are channel B
  typedef logic [1:0] half_t;

  typedef logic chan_t;   // 0 = A, 1 = B

endpackage

`default_nettype wire

// File: design/axi_pkg.sv
// ----------------------------------------------------------------------
// AXI types
// write response codes and burst types of the HP write port
// ----------------------------------------------------------------------
`default_nettype none

package axi_pkg;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,   // slave error, flagged by the writer
    RESP_DECERR = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,   // the only type the dump issues
    BURST_WRAP  = 2'b10
  } burst_e;

endpackage

`default_nettype wire

// File: design/dump_params.svh
// ----------------------------------------------------------------------
// ADC dump engine parameters
// widths, burst geometry and channel count shared by the dump blocks
// ----------------------------------------------------------------------
`ifndef DUMP_PARAMS_SVH
`define DUMP_PARAMS_SVH

`define DUMP_AXI_AW           32    // HP port address width
`define DUMP_AXI_DW           64    // HP port data width
`define DUMP_BUF_AW           9     // sample buffer read address width

`define DUMP_BURST_LEN        16    // beats per AXI3 burst
`define DUMP_BURST_BYTES      128   // 16 beats of 8 bytes
`define DUMP_BURSTS_PER_HALF  16    // 256 words per buffer half

`define DUMP_CH               2     // channel A and channel B

`endif
